// ==== design/hash_cfg.svh ====
`ifndef HASH_CFG_SVH
`define HASH_CFG_SVH

// ======================================================================
// bus side
// ======================================================================
`define HASH_IO_ADDR_WIDTH 22

// word offsets within the low 9 address bits
`define HASH_REG_CLEAR  9'h100
`define HASH_REG_FEED1  9'h104
`define HASH_REG_FEED2  9'h108
`define HASH_REG_FEED4  9'h10C
`define HASH_REG_RESULT 9'h110

// ======================================================================
// toeplitz key
// ======================================================================
`define HASH_KEY_BITS 320
`define HASH_KEY 320'h6d5a56da255b0ec24167253d43a38fb0d0ca2bcbae7b30b477cb2da38030f20c6a42b73bbeac01fa
`define HASH_MAX_BYTES 36 // key length less the 4-byte window

`endif

// ==== design/hash_pkg.sv ====
package hash_pkg;

  // ====================================================================
  // request opcodes
  // ====================================================================
  typedef enum logic [1:0] {
    op_none,
    op_clear,
    op_feed
  } hash_op_e;

  // stage 1 -> stage 2
  typedef struct packed {
    hash_op_e    op;
    logic [31:0] data;
    logic [2:0]  cnt;    // bytes in data, 1/2/4
  } hash_req_t;

  // stage 2 -> stage 3
  typedef struct packed {
    logic        clear;
    logic        valid;
    logic [31:0] data;
    logic [2:0]  cnt;    // trimmed to the input cap
    logic [62:0] window; // key bits 8*ofs .. 8*ofs+62, msb first
  } hash_step_t;

endpackage

// ==== design/io_decode.sv ====
`timescale 1ns/1ps
`include "hash_cfg.svh"

module io_decode (
  input  logic                           clk,
  input  logic                           rst,

  input  logic                           io_en,
  input  logic                           io_wen,
  input  logic [`HASH_IO_ADDR_WIDTH-1:0] io_addr,
  input  logic [31:0]                    io_wr_data,

  input  logic [31:0]                    hash_value,

  output hash_pkg::hash_req_t            req,
  output logic [31:0]                    io_rd_data,
  output logic                           io_rd_valid
);

  import hash_pkg::*;

  logic [8:0] word_ofs;
  logic       wr_acc;
  logic       rd_hit;
  hash_op_e   op_nxt;
  logic [2:0] cnt_nxt;

  assign word_ofs = {io_addr[8:2], 2'b00}; // byte lanes ignored
  assign wr_acc   = io_en && io_wen;
  assign rd_hit   = io_en && !io_wen && (word_ofs == `HASH_REG_RESULT);

  // ====================================================================
  // write decode
  // ====================================================================
  always_comb begin
    op_nxt  = op_none;
    cnt_nxt = 3'd4;
    case (word_ofs)
      `HASH_REG_CLEAR: op_nxt = op_clear;
      `HASH_REG_FEED1: begin
        op_nxt  = op_feed;
        cnt_nxt = 3'd1;
      end
      `HASH_REG_FEED2: begin
        op_nxt  = op_feed;
        cnt_nxt = 3'd2;
      end
      `HASH_REG_FEED4: op_nxt = op_feed;
      default: op_nxt = op_none; // unmapped, dropped
    endcase
  end

  always_ff @(posedge clk) begin
    req.data <= io_wr_data;
    req.cnt  <= cnt_nxt;

    if (rst) begin
      req.op <= op_none;
    end else begin
      req.op <= wr_acc ? op_nxt : op_none;
    end
  end

  // ====================================================================
  // result readback
  // ====================================================================
  always_ff @(posedge clk) begin
    if (rd_hit) begin
      io_rd_data <= hash_value;
    end

    if (rst) begin
      io_rd_valid <= 1'b0;
    end else begin
      io_rd_valid <= rd_hit; // one-cycle pulse
    end
  end

endmodule

// ==== design/key_window.sv ====
`timescale 1ns/1ps
`include "hash_cfg.svh"

module key_window (
  input  logic                clk,
  input  logic                rst,

  input  hash_pkg::hash_req_t req,
  output hash_pkg::hash_step_t step
);

  import hash_pkg::*;

  localparam int OFS_W = $clog2(`HASH_MAX_BYTES + 1);
  localparam int WIN_W = 63;
  localparam int PAD_W = `HASH_KEY_BITS + WIN_W;

  // key padded with zeros so a window near the end never runs off
  localparam logic [PAD_W-1:0] KEY_PAD = {`HASH_KEY, {WIN_W{1'b0}}};
  localparam logic [OFS_W-1:0] MAX_OFS = OFS_W'(`HASH_MAX_BYTES);

  logic [OFS_W-1:0] offset;   // stream position in bytes
  logic [OFS_W-1:0] room;
  logic [2:0]       cnt_trim;
  logic [PAD_W-1:0] key_shift;
  logic             is_feed;
  logic             is_clear;

  assign is_feed  = (req.op == op_feed);
  assign is_clear = (req.op == op_clear);

  // ====================================================================
  // input cap
  // ====================================================================
  always_comb begin
    room = MAX_OFS - offset;
    if (OFS_W'(req.cnt) > room) begin
      cnt_trim = room[2:0]; // room < 4 here
    end else begin
      cnt_trim = req.cnt;
    end
  end

  // window starts at key bit 8*offset, counted from the msb
  assign key_shift = KEY_PAD << {offset, 3'b000};

  // ====================================================================
  // offset and step register
  // ====================================================================
  always_ff @(posedge clk) begin
    step.data   <= req.data;
    step.cnt    <= cnt_trim;
    step.window <= key_shift[PAD_W-1 -: WIN_W];

    if (rst) begin
      offset     <= '0;
      step.clear <= 1'b0;
      step.valid <= 1'b0;
    end else begin
      step.clear <= is_clear;
      step.valid <= is_feed && (cnt_trim != 3'd0);
      if (is_clear) begin
        offset <= '0;
      end else if (is_feed) begin
        offset <= offset + OFS_W'(cnt_trim); // stops at the cap
      end
    end
  end

endmodule

// ==== design/hash_accum.sv ====
`timescale 1ns/1ps

module hash_accum (
  input  logic                 clk,
  input  logic                 rst,

  input  hash_pkg::hash_step_t step,
  output logic [31:0]          hash_value
);

  logic [3:0]  lane_en;   // byte lanes inside the count
  logic [31:0] stream;    // data bits in stream order, bit k is stream bit k
  logic [31:0] fold;

  // ====================================================================
  // byte lanes and bit order
  // ====================================================================
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      lane_en[i] = (i < int'(step.cnt));
    end
  end

  // first byte in bits 7:0, each byte taken msb first
  always_comb begin
    for (int k = 0; k < 32; k++) begin
      stream[k] = step.data[8*(k/8) + 7 - (k%8)] && lane_en[k/8];
    end
  end

  // ====================================================================
  // xor of the key slices
  // ====================================================================
  always_comb begin
    fold = '0;
    for (int k = 0; k < 32; k++) begin
      if (stream[k]) begin
        fold = fold ^ step.window[62-k -: 32];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hash_value <= '0;
    end else if (step.clear) begin
      hash_value <= '0;
    end else if (step.valid) begin
      hash_value <= hash_value ^ fold;
    end
  end

endmodule

// ==== design/hash_accel_top.sv ====
`timescale 1ns/1ps
`include "hash_cfg.svh"

module hash_accel_top (
  input  logic                           clk,
  input  logic                           rst,

  input  logic                           io_en,
  input  logic                           io_wen,
  input  logic [`HASH_IO_ADDR_WIDTH-1:0] io_addr,
  input  logic [31:0]                    io_wr_data,
  output logic [31:0]                    io_rd_data,
  output logic                           io_rd_valid
);

  import hash_pkg::*;

  hash_req_t   req;
  hash_step_t  step;
  logic [31:0] hash_value;

  // ====================================================================
  // three stage pipeline
  // ====================================================================
  io_decode u_decode (
    .clk        (clk),
    .rst        (rst),
    .io_en      (io_en),
    .io_wen     (io_wen),
    .io_addr    (io_addr),
    .io_wr_data (io_wr_data),
    .hash_value (hash_value),
    .req        (req),
    .io_rd_data (io_rd_data),
    .io_rd_valid(io_rd_valid)
  );

  key_window u_window (
    .clk (clk),
    .rst (rst),
    .req (req),
    .step(step)
  );

  hash_accum u_accum (
    .clk       (clk),
    .rst       (rst),
    .step      (step),
    .hash_value(hash_value) // back to stage 1 for readback
  );

endmodule

// ==== dv/hash_accel_asserts.sv ====
`timescale 1ns/1ps
`include "hash_cfg.svh"

module hash_accel_asserts #(
  parameter int OFS_W = $clog2(`HASH_MAX_BYTES + 1)
) (
  input logic                           clk,
  input logic                           rst,
  input logic                           io_en,
  input logic                           io_wen,
  input logic [`HASH_IO_ADDR_WIDTH-1:0] io_addr,
  input logic                           io_rd_valid,
  input hash_pkg::hash_req_t            req,
  input hash_pkg::hash_step_t           step,
  input logic [OFS_W-1:0]               offset,
  input logic [31:0]                    hash_value
);

  import hash_pkg::*;

  localparam logic [OFS_W-1:0] MAX_OFS = OFS_W'(`HASH_MAX_BYTES);

  int   err_cnt = 0; // watched by the testbench
  logic rd_req;

  assign rd_req = io_en && !io_wen && ({io_addr[8:2], 2'b00} == `HASH_REG_RESULT);

  // ====================================================================
  // readback strobe
  // ====================================================================
  a_rd_follow: assert property (@(posedge clk) disable iff (rst) rd_req |=> io_rd_valid)
    else begin err_cnt++; $error("rd_valid missing after result read"); end
  a_rd_cause: assert property (@(posedge clk) disable iff (rst) io_rd_valid |-> $past(rd_req))
    else begin err_cnt++; $error("rd_valid without a result read"); end
  a_rd_pulse: assert property (@(posedge clk) disable iff (rst) io_rd_valid |=> !io_rd_valid)
    else begin err_cnt++; $error("rd_valid high two cycles in a row"); end

  // ====================================================================
  // pipeline state
  // ====================================================================
  a_ofs_cap: assert property (@(posedge clk) disable iff (rst) offset <= MAX_OFS)
    else begin err_cnt++; $error("byte offset past the input cap"); end
  a_clear: assert property (@(posedge clk) disable iff (rst) step.clear |=> hash_value == '0)
    else begin err_cnt++; $error("hash not zero after clear"); end

  // reset values one cycle after rst is sampled
  a_reset: assert property (@(posedge clk) rst |=> (!io_rd_valid && req.op == op_none &&
      !step.clear && !step.valid && offset == '0 && hash_value == '0))
    else begin err_cnt++; $error("pipeline not idle after reset"); end

endmodule

// ==== dv/tb_hash_accel.sv ====
`timescale 1ns/1ps
`include "hash_cfg.svh"

module tb_hash_accel;

  localparam int MAX_CYCLES = 4000; // all tests need well under 1000

  logic                           clk;
  logic                           rst;
  logic                           io_en;
  logic                           io_wen;
  logic [`HASH_IO_ADDR_WIDTH-1:0] io_addr;
  logic [31:0]                    io_wr_data;
  logic [31:0]                    io_rd_data;
  logic                           io_rd_valid;

  logic [31:0] lfsr = 32'd32;
  logic [7:0]  stream_q[$]; // bytes fed since the last clear
  logic [31:0] exp_q[$];    // expected readbacks in order
  int          cycle_cnt = 0;

  hash_accel_top DUT (.*);

  bind hash_accel_top hash_accel_asserts u_asserts (
    .clk(clk), .rst(rst), .io_en(io_en), .io_wen(io_wen), .io_addr(io_addr),
    .io_rd_valid(io_rd_valid), .req(req), .step(step),
    .offset(u_window.offset), .hash_value(hash_value)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ====================================================================
  // random bits and reference model
  // ====================================================================
  function automatic logic next_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ 32'h80200003;
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], next_bit()};
    return v;
  endfunction

  // toeplitz over the first HASH_MAX_BYTES stream bytes, msb of each byte first
  function automatic logic [31:0] model_hash();
    logic [`HASH_KEY_BITS-1:0] key;
    logic [31:0]               h;
    int                        n;
    key = `HASH_KEY;
    h = '0;
    for (int i = 0; i < stream_q.size() && i < `HASH_MAX_BYTES; i++) begin
      for (int b = 0; b < 8; b++) begin
        n = 8 * i + b;
        if (stream_q[i][7-b]) h = h ^ key[`HASH_KEY_BITS-1-n -: 32];
      end
    end
    return h;
  endfunction

  // ====================================================================
  // bus tasks, all called right after a rising edge
  // ====================================================================
  task automatic bus_idle(input int n);
    io_en  <= 1'b0;
    io_wen <= 1'b0;
    repeat (n) @(posedge clk);
  endtask

  task automatic bus_write(input logic [8:0] ofs, input logic [31:0] data);
    io_en      <= 1'b1;
    io_wen     <= 1'b1;
    io_addr    <= {13'd0, ofs};
    io_wr_data <= data;
    @(posedge clk);
  endtask

  task automatic hash_clear();
    stream_q.delete();
    bus_write(`HASH_REG_CLEAR, rand_bits(32));
  endtask

  task automatic feed(input int cnt);
    logic [31:0] data;
    logic [8:0]  ofs;
    data = rand_bits(32); // upper lanes hold junk on short feeds
    ofs = (cnt == 1) ? `HASH_REG_FEED1 : (cnt == 2) ? `HASH_REG_FEED2 : `HASH_REG_FEED4;
    for (int i = 0; i < cnt; i++) stream_q.push_back(data[8*i +: 8]);
    bus_write(ofs, data);
  endtask

  task automatic feed_random();
    logic [31:0] sel;
    sel = rand_bits(2);
    feed((sel == 0) ? 1 : (sel == 1) ? 2 : 4);
  endtask

  // read sampled three edges after the last write
  task automatic read_result();
    bus_idle(2);
    exp_q.push_back(model_hash());
    io_en   <= 1'b1;
    io_wen  <= 1'b0;
    io_addr <= {13'd0, `HASH_REG_RESULT};
    @(posedge clk);
    bus_idle(1);
  endtask

  // ====================================================================
  // checks and run limit
  // ====================================================================
  always @(posedge clk) begin : readback_check
    logic [31:0] exp_val;
    if (!rst && io_rd_valid) begin
      assert (exp_q.size() > 0) else begin
        $display("read data returned with no read pending");
        $display("SIMULATION FAILED");
        $fatal(1, "unexpected readback");
      end
      exp_val = exp_q.pop_front();
      assert (io_rd_data == exp_val) else begin
        $display("FAILED time=%0t io_rd_data got=%h exp=%h", $time, io_rd_data, exp_val);
        $display("SIMULATION FAILED");
        $fatal(1, "readback mismatch");
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (DUT.u_asserts.err_cnt != 0) begin
      $display("a pipeline assertion failed");
      $display("SIMULATION FAILED");
      $fatal(1, "assertion failure");
    end else if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $fatal(1, "timeout");
    end
  end

  // ====================================================================
  // test sequence
  // ====================================================================
  initial begin
    rst        = 1'b1;
    io_en      = 1'b0;
    io_wen     = 1'b0;
    io_addr    = '0;
    io_wr_data = '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    bus_idle(5);
    read_result();              // nothing fed yet

    hash_clear();
    for (int i = 0; i < 4; i++) begin
      feed(4);
      read_result();
    end

    for (int r = 0; r < 3; r++) begin
      hash_clear();             // clear and feeds back to back
      for (int i = 0; i < 6; i++) feed_random();
      read_result();
    end

    hash_clear();
    feed(2);                    // cap lands inside a feed-4 word
    for (int i = 0; i < 12; i++) feed(4); // 50 bytes, past the cap
    read_result();
    feed(1);
    read_result();

    hash_clear();
    for (int i = 0; i < 3; i++) feed_random();
    hash_clear();
    bus_write(9'h114, rand_bits(32)); // unmapped
    feed_random();
    bus_write(`HASH_REG_RESULT, rand_bits(32));
    feed_random();
    bus_write(9'h0F0, rand_bits(32));
    read_result();

    while (exp_q.size() != 0) @(posedge clk);
    bus_idle(4);
    if (DUT.u_asserts.err_cnt == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("a pipeline assertion failed");
      $display("SIMULATION FAILED");
      $fatal(1, "assertion failure");
    end
  end

endmodule

// ==== sources.f ====
+incdir+design
design/hash_pkg.sv
design/io_decode.sv
design/key_window.sv
design/hash_accum.sv
design/hash_accel_top.sv
dv/hash_accel_asserts.sv
dv/tb_hash_accel.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_hash_accel
FILELIST  = sources.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# the run passes only when the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
